/* Bender.yml */
package:
  name: mipscore

sources:
  - files:
      - hdl/mipsPkg.sv
      - hdl/hazardBus.sv
      - hdl/pipeReg.sv
      - hdl/fetchStage.sv
      - hdl/decodeStage.sv
      - hdl/hazardCtrl.sv
      - hdl/executeStage.sv
      - hdl/memoryStage.sv
      - hdl/mipsCore.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/mipsTb.sv

/* hdl/decodeStage.sv */
// decodeStage decodes instructions, extends immediates and keeps the register file
`timescale 1ns/10ps

module decodeStage (
	input logic clk,
	input logic rstN,
	input mipsPkg::ifIdT decIn,
	hazardBus.decode hz,
	input logic wbEn,
	input mipsPkg::regAddrT wbDest,
	input mipsPkg::wordT wbData,
	output mipsPkg::idExT decOut
);

	mipsPkg::wordT regs [32];
	mipsPkg::opcodeT opcode;
	mipsPkg::functT funct;
	mipsPkg::regAddrT rs;
	mipsPkg::regAddrT rt;
	mipsPkg::regAddrT rd;
	mipsPkg::regAddrT dest;
	mipsPkg::wordT rsVal;
	mipsPkg::wordT rtVal;
	mipsPkg::aluOpT aluOp;
	mipsPkg::brTypeT brType;
	logic usesRs;
	logic readsRt;
	logic writes;
	logic useRd;
	logic isImm;
	logic memRd;
	logic memWr;

	assign opcode = decIn.instr[31:26];
	assign rs = decIn.instr[25:21];
	assign rt = decIn.instr[20:16];
	assign rd = decIn.instr[15:11];
	assign funct = decIn.instr[5:0];
	assign dest = useRd ? rd : rt;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			regs <= '{default: '0};
		end else if (wbEn && wbDest != '0) begin
			regs[wbDest] <= wbData;
		end
	end

	// a register being written this cycle reads the new value
	assign rsVal = (rs == '0) ? '0 : (wbEn && wbDest == rs) ? wbData : regs[rs];
	assign rtVal = (rt == '0) ? '0 : (wbEn && wbDest == rt) ? wbData : regs[rt];

	always_comb begin
		usesRs = 1'b0;
		readsRt = 1'b0;
		writes = 1'b0;
		useRd = 1'b0;
		isImm = 1'b0;
		memRd = 1'b0;
		memWr = 1'b0;
		aluOp = mipsPkg::ALU_ADD;
		brType = mipsPkg::BR_NONE;
		if (decIn.valid) begin
			case (opcode)
				mipsPkg::OP_RTYPE: begin
					case (funct)
						mipsPkg::FN_ADD: aluOp = mipsPkg::ALU_ADD;
						mipsPkg::FN_SUB: aluOp = mipsPkg::ALU_SUB;
						mipsPkg::FN_AND: aluOp = mipsPkg::ALU_AND;
						mipsPkg::FN_OR: aluOp = mipsPkg::ALU_OR;
						mipsPkg::FN_SLT: aluOp = mipsPkg::ALU_SLT;
						default: aluOp = mipsPkg::ALU_ADD;
					endcase
					// unknown funct stays a no-op
					if (funct inside {mipsPkg::FN_ADD, mipsPkg::FN_SUB, mipsPkg::FN_AND,
							mipsPkg::FN_OR, mipsPkg::FN_SLT}) begin
						usesRs = 1'b1;
						readsRt = 1'b1;
						writes = 1'b1;
						useRd = 1'b1;
					end
				end
				mipsPkg::OP_ADDI: begin
					usesRs = 1'b1;
					isImm = 1'b1;
					writes = 1'b1;
				end
				mipsPkg::OP_LW: begin
					usesRs = 1'b1;
					isImm = 1'b1;
					memRd = 1'b1;
					writes = 1'b1;
				end
				mipsPkg::OP_SW: begin
					usesRs = 1'b1;
					readsRt = 1'b1;
					isImm = 1'b1;
					memWr = 1'b1;
				end
				mipsPkg::OP_BEQ: begin
					usesRs = 1'b1;
					readsRt = 1'b1;
					brType = mipsPkg::BR_BEQ;
				end
				mipsPkg::OP_BNE: begin
					usesRs = 1'b1;
					readsRt = 1'b1;
					brType = mipsPkg::BR_BNE;
				end
				default: begin
				end
			endcase
		end
	end

	always_comb begin
		decOut.pcPlus4 = decIn.pcPlus4;
		decOut.rsVal = rsVal;
		decOut.rtVal = rtVal;
		decOut.imm = {{16{decIn.instr[15]}}, decIn.instr[15:0]};
		decOut.dest = dest;
		// writes to r0 are dropped here so nothing downstream sees them
		decOut.wbEn = writes && dest != '0;
		decOut.memRdEn = memRd;
		decOut.memWrEn = memWr;
		decOut.isImm = isImm;
		decOut.aluOp = aluOp;
		decOut.brType = brType;
		decOut.valid = decIn.valid;
	end

	// r0 as source never creates a dependency
	assign hz.src1 = usesRs ? rs : '0;
	assign hz.src2 = rt;
	assign hz.readsSrc2 = readsRt;

	wbToZero: assert property (@(posedge clk) disable iff (!rstN) wbEn |-> wbDest != '0);

endmodule

/* hdl/executeStage.sv */
// executeStage holds the ALU, the branch compare and the branch target adder
`timescale 1ns/10ps

module executeStage (
	input mipsPkg::idExT exIn,
	hazardBus.execute hz,
	output mipsPkg::exMemT exOut,
	output mipsPkg::wordT branchTarget
);

	mipsPkg::wordT opB;
	mipsPkg::wordT aluRes;
	logic taken;

	assign opB = exIn.isImm ? exIn.imm : exIn.rtVal;

	always_comb begin
		case (exIn.aluOp)
			mipsPkg::ALU_ADD: aluRes = exIn.rsVal + opB;
			mipsPkg::ALU_SUB: aluRes = exIn.rsVal - opB;
			mipsPkg::ALU_AND: aluRes = exIn.rsVal & opB;
			mipsPkg::ALU_OR: aluRes = exIn.rsVal | opB;
			mipsPkg::ALU_SLT: aluRes = ($signed(exIn.rsVal) < $signed(opB)) ? 32'd1 : 32'd0;
			default: aluRes = exIn.rsVal + opB;
		endcase
	end

	always_comb begin
		taken = 1'b0;
		if (exIn.valid) begin
			case (exIn.brType)
				mipsPkg::BR_BEQ: taken = (exIn.rsVal == exIn.rtVal);
				mipsPkg::BR_BNE: taken = (exIn.rsVal != exIn.rtVal);
				default: taken = 1'b0;
			endcase
		end
	end

	// word offset relative to the next instruction
	assign branchTarget = exIn.pcPlus4 + (exIn.imm << 2);

	always_comb begin
		exOut.result = aluRes;
		exOut.storeData = exIn.rtVal;
		exOut.dest = exIn.dest;
		exOut.wbEn = exIn.valid && exIn.wbEn;
		exOut.memRdEn = exIn.valid && exIn.memRdEn;
		exOut.memWrEn = exIn.valid && exIn.memWrEn;
		exOut.valid = exIn.valid;
	end

	assign hz.exDest = exIn.dest;
	assign hz.exWbEn = exIn.valid && exIn.wbEn;
	assign hz.branchTaken = taken;

endmodule

/* hdl/fetchStage.sv */
// fetchStage holds the program counter and the instruction memory with its program load port
`timescale 1ns/10ps

module fetchStage #(
	parameter int IMEM_DEPTH = 256
) (
	input logic clk,
	input logic rstN,
	input logic run,
	input logic progWe,
	input logic [7:0] progAddr,
	input mipsPkg::wordT progData,
	hazardBus.fetch hz,
	input mipsPkg::wordT branchTarget,
	output mipsPkg::ifIdT fetchOut
);

	localparam int IDX_W = $clog2(IMEM_DEPTH);

	mipsPkg::wordT imem [IMEM_DEPTH];
	mipsPkg::wordT pc;
	logic [IDX_W-1:0] pcIdx;
	logic [IDX_W-1:0] progIdx;

	assign pcIdx = pc[IDX_W+1:2];
	assign progIdx = IDX_W'(progAddr);

	always_ff @(posedge clk) begin
		if (progWe) begin
			imem[progIdx] <= progData;
		end
	end

	// branch redirect beats a stall
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
		end else if (hz.flush) begin
			pc <= branchTarget;
		end else if (run && !hz.stall) begin
			pc <= pc + 32'd4;
		end
	end

	always_comb begin
		fetchOut.instr = imem[pcIdx];
		fetchOut.pcPlus4 = pc + 32'd4;
		fetchOut.valid = run;
	end

	// loading is only legal while the core is halted
	progWhileRun: assert property (@(posedge clk) disable iff (!rstN) !(progWe && run));

endmodule

/* hdl/hazardBus.sv */
// hazardBus interface for dependencies, branch outcome, stall and flush around hazard control
`timescale 1ns/10ps

interface hazardBus (
	input logic clk,
	input logic rstN
);

	// source registers read by the instruction in decode
	mipsPkg::regAddrT src1;
	mipsPkg::regAddrT src2;
	logic readsSrc2;

	// producers still in flight
	mipsPkg::regAddrT exDest;
	logic exWbEn;
	mipsPkg::regAddrT memDest;
	logic memWbEn;

	logic branchTaken;

	logic stall;
	logic flush;

	modport decode (
		output src1,
		output src2,
		output readsSrc2
	);

	modport execute (
		output exDest,
		output exWbEn,
		output branchTaken
	);

	modport memory (
		output memDest,
		output memWbEn
	);

	modport ctrl (
		input clk,
		input rstN,
		input src1,
		input src2,
		input readsSrc2,
		input exDest,
		input exWbEn,
		input memDest,
		input memWbEn,
		input branchTaken,
		output stall,
		output flush
	);

	// fetch only listens to the control decision
	modport fetch (
		input stall,
		input flush
	);

endinterface

/* hdl/hazardCtrl.sv */
// hazardCtrl stalls on pending register producers and flushes on taken branches
`timescale 1ns/10ps

module hazardCtrl (
	hazardBus.ctrl hz
);

	logic src1Hit;
	logic src2Hit;

	// no forwarding, so wait until the producer reaches writeback
	assign src1Hit = (hz.src1 != '0)
		&& ((hz.exWbEn && hz.exDest != '0 && hz.exDest == hz.src1)
		|| (hz.memWbEn && hz.memDest != '0 && hz.memDest == hz.src1));

	assign src2Hit = hz.readsSrc2 && (hz.src2 != '0)
		&& ((hz.exWbEn && hz.exDest != '0 && hz.exDest == hz.src2)
		|| (hz.memWbEn && hz.memDest != '0 && hz.memDest == hz.src2));

	assign hz.stall = src1Hit | src2Hit;
	assign hz.flush = hz.branchTaken;

	// a producer leaves memory after at most two bubbles
	stallBound: assert property (@(posedge hz.clk) disable iff (!hz.rstN)
		not (hz.stall [*3]));

endmodule

/* hdl/memoryStage.sv */
// memoryStage handles data memory access, the store strobe and the writeback result select
`timescale 1ns/10ps

module memoryStage #(
	parameter int DMEM_DEPTH = 256
) (
	input logic clk,
	input logic rstN,
	input mipsPkg::exMemT memIn,
	hazardBus.memory hz,
	output mipsPkg::memWbT memOut,
	output logic memWe,
	output mipsPkg::wordT memAddr,
	output mipsPkg::wordT memWdata
);

	localparam int IDX_W = $clog2(DMEM_DEPTH);

	mipsPkg::wordT dmem [DMEM_DEPTH];
	logic [IDX_W-1:0] dIdx;

	// byte address to word index
	assign dIdx = memIn.result[IDX_W+1:2];

	assign memWe = memIn.valid && memIn.memWrEn;
	assign memAddr = memIn.result;
	assign memWdata = memIn.storeData;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			dmem <= '{default: '0};
		end else if (memWe) begin
			dmem[dIdx] <= memIn.storeData;
		end
	end

	always_comb begin
		memOut.result = memIn.memRdEn ? dmem[dIdx] : memIn.result;
		memOut.dest = memIn.dest;
		memOut.wbEn = memIn.valid && memIn.wbEn;
		memOut.valid = memIn.valid;
	end

	assign hz.memDest = memIn.dest;
	assign hz.memWbEn = memIn.valid && memIn.wbEn;

	wordAligned: assert property (@(posedge clk) disable iff (!rstN)
		memIn.valid && (memIn.memRdEn || memIn.memWrEn) |-> memIn.result[1:0] == 2'b00);

endmodule

/* hdl/mipsCore.sv */
// mipsCore ties the five pipeline stages, their stage registers and hazard control together
`timescale 1ns/10ps

module mipsCore #(
	parameter int IMEM_DEPTH = 256,
	parameter int DMEM_DEPTH = 256
) (
	input logic clk,
	input logic rstN,
	input logic run,
	input logic progWe,
	input logic [7:0] progAddr,
	input mipsPkg::wordT progData,
	output logic wbValid,
	output mipsPkg::regAddrT wbDest,
	output mipsPkg::wordT wbData,
	output logic memWe,
	output mipsPkg::wordT memAddr,
	output mipsPkg::wordT memWdata
);

	mipsPkg::ifIdT ifD, ifQ;
	mipsPkg::idExT idD, idQ;
	mipsPkg::exMemT exD, exQ;
	mipsPkg::memWbT memD, memQ;
	mipsPkg::wordT branchTarget;
	logic idExClear;

	hazardBus hzBus (.clk(clk), .rstN(rstN));

	// a stalled decode hands a bubble to execute
	assign idExClear = hzBus.stall | hzBus.flush;

	assign wbValid = memQ.wbEn;
	assign wbDest = memQ.dest;
	assign wbData = memQ.result;

	fetchStage #(.IMEM_DEPTH(IMEM_DEPTH)) fetch_i (
		.clk(clk), .rstN(rstN), .run(run), .progWe(progWe), .progAddr(progAddr),
		.progData(progData), .hz(hzBus), .branchTarget(branchTarget), .fetchOut(ifD)
	);

	pipeReg #(.payloadT(mipsPkg::ifIdT)) ifId_i (
		.clk(clk), .rstN(rstN), .stall(hzBus.stall), .flush(hzBus.flush), .d(ifD), .q(ifQ)
	);

	decodeStage decode_i (
		.clk(clk), .rstN(rstN), .decIn(ifQ), .hz(hzBus), .wbEn(memQ.wbEn),
		.wbDest(memQ.dest), .wbData(memQ.result), .decOut(idD)
	);

	hazardCtrl hazard_i (.hz(hzBus));

	pipeReg #(.payloadT(mipsPkg::idExT)) idEx_i (
		.clk(clk), .rstN(rstN), .stall(1'b0), .flush(idExClear), .d(idD), .q(idQ)
	);

	executeStage execute_i (
		.exIn(idQ), .hz(hzBus), .exOut(exD), .branchTarget(branchTarget)
	);

	pipeReg #(.payloadT(mipsPkg::exMemT)) exMem_i (
		.clk(clk), .rstN(rstN), .stall(1'b0), .flush(1'b0), .d(exD), .q(exQ)
	);

	memoryStage #(.DMEM_DEPTH(DMEM_DEPTH)) memory_i (
		.clk(clk), .rstN(rstN), .memIn(exQ), .hz(hzBus), .memOut(memD),
		.memWe(memWe), .memAddr(memAddr), .memWdata(memWdata)
	);

	pipeReg #(.payloadT(mipsPkg::memWbT)) memWb_i (
		.clk(clk), .rstN(rstN), .stall(1'b0), .flush(1'b0), .d(memD), .q(memQ)
	);

endmodule

/* hdl/mipsPkg.sv */
// mipsPkg package with the shared word, register, opcode, control and stage payload types
package mipsPkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0] regAddrT;
	typedef logic [5:0] opcodeT;
	typedef logic [5:0] functT;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} aluOpT;

	typedef enum logic [1:0] {
		BR_NONE,
		BR_BEQ,
		BR_BNE
	} brTypeT;

	localparam opcodeT OP_RTYPE = 6'h00;
	localparam opcodeT OP_ADDI = 6'h08;
	localparam opcodeT OP_LW = 6'h23;
	localparam opcodeT OP_SW = 6'h2B;
	localparam opcodeT OP_BEQ = 6'h04;
	localparam opcodeT OP_BNE = 6'h05;

	localparam functT FN_ADD = 6'h20;
	localparam functT FN_SUB = 6'h22;
	localparam functT FN_AND = 6'h24;
	localparam functT FN_OR = 6'h25;
	localparam functT FN_SLT = 6'h2A;

	typedef struct packed {
		wordT instr;
		wordT pcPlus4;
		logic valid;
	} ifIdT;

	typedef struct packed {
		wordT pcPlus4;
		wordT rsVal;
		wordT rtVal;
		wordT imm;
		regAddrT dest;
		logic wbEn;
		logic memRdEn;
		logic memWrEn;
		logic isImm;
		aluOpT aluOp;
		brTypeT brType;
		logic valid;
	} idExT;

	typedef struct packed {
		wordT result;
		wordT storeData;
		regAddrT dest;
		logic wbEn;
		logic memRdEn;
		logic memWrEn;
		logic valid;
	} exMemT;

	typedef struct packed {
		wordT result;
		regAddrT dest;
		logic wbEn;
		logic valid;
	} memWbT;

endpackage

/* hdl/pipeReg.sv */
// pipeReg pipeline stage register that holds on stall and loads a bubble on flush
`timescale 1ns/10ps

module pipeReg #(
	parameter type payloadT = logic
) (
	input logic clk,
	input logic rstN,
	input logic stall,
	input logic flush,
	input payloadT d,
	output payloadT q
);

	// all zeros is a bubble since valid clears too
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			q <= '0;
		end else if (flush) begin
			q <= '0;
		end else if (!stall) begin
			q <= d;
		end
	end

endmodule

/* sim.f */
+incdir+test
hdl/mipsPkg.sv
hdl/hazardBus.sv
hdl/pipeReg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/hazardCtrl.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/mipsCore.sv
test/mipsTb.sv

/* test/mipsTests.svh */
// mipsTests holds the instruction encoders and directed test programs for the core

function automatic mipsPkg::wordT encR(mipsPkg::functT fn, mipsPkg::regAddrT rd,
		mipsPkg::regAddrT rs, mipsPkg::regAddrT rt);
	return {mipsPkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

function automatic mipsPkg::wordT encI(mipsPkg::opcodeT op, mipsPkg::regAddrT rt,
		mipsPkg::regAddrT rs, logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

task automatic testAluChain();
	logic [15:0] immA;
	logic [15:0] immB;
	mipsPkg::wordT a;
	mipsPkg::wordT b;
	curTest = "aluChain";
	immA = randHalf();
	immB = randHalf();
	a = sext16(immA);
	b = sext16(immB);
	emit(encI(mipsPkg::OP_ADDI, 5'd1, 5'd0, immA));
	emit(encI(mipsPkg::OP_ADDI, 5'd2, 5'd0, immB));
	emit(encR(mipsPkg::FN_ADD, 5'd3, 5'd1, 5'd2));
	emit(encR(mipsPkg::FN_SUB, 5'd4, 5'd1, 5'd2));
	emit(encR(mipsPkg::FN_AND, 5'd5, 5'd1, 5'd2));
	emit(encR(mipsPkg::FN_OR, 5'd6, 5'd1, 5'd2));
	emit(encR(mipsPkg::FN_SLT, 5'd7, 5'd1, 5'd2));
	emit(encR(mipsPkg::FN_SLT, 5'd8, 5'd2, 5'd1));
	expectWb(5'd1, a);
	expectWb(5'd2, b);
	expectWb(5'd3, a + b);
	expectWb(5'd4, a - b);
	expectWb(5'd5, a & b);
	expectWb(5'd6, a | b);
	expectWb(5'd7, sltValue(a, b));
	expectWb(5'd8, sltValue(b, a));
	runProgram();
endtask

// each instruction needs the result of the one before
task automatic testDependency();
	logic [15:0] immC;
	logic [15:0] immD;
	logic [15:0] immE;
	mipsPkg::wordT r1;
	curTest = "dependency";
	immC = randHalf();
	immD = randHalf();
	immE = randHalf();
	r1 = sext16(immC) + sext16(immD);
	emit(encI(mipsPkg::OP_ADDI, 5'd1, 5'd0, immC));
	emit(encI(mipsPkg::OP_ADDI, 5'd1, 5'd1, immD));
	emit(encR(mipsPkg::FN_ADD, 5'd2, 5'd1, 5'd1));
	emit(encR(mipsPkg::FN_SUB, 5'd3, 5'd2, 5'd1));
	emit(encI(mipsPkg::OP_ADDI, 5'd4, 5'd3, immE));
	expectWb(5'd1, sext16(immC));
	expectWb(5'd1, r1);
	expectWb(5'd2, r1 + r1);
	expectWb(5'd3, r1);
	expectWb(5'd4, r1 + sext16(immE));
	runProgram();
endtask

task automatic testStoreLoad();
	logic [15:0] immV;
	curTest = "storeLoad";
	immV = randHalf();
	emit(encI(mipsPkg::OP_ADDI, 5'd1, 5'd0, 16'h0040));
	emit(encI(mipsPkg::OP_ADDI, 5'd2, 5'd0, immV));
	emit(encI(mipsPkg::OP_SW, 5'd2, 5'd1, 16'd8));
	emit(encI(mipsPkg::OP_LW, 5'd4, 5'd1, 16'd8));
	// never stored, so still zero
	emit(encI(mipsPkg::OP_LW, 5'd5, 5'd1, 16'd4));
	expectWb(5'd1, 32'h40);
	expectWb(5'd2, sext16(immV));
	expectWb(5'd4, sext16(immV));
	expectWb(5'd5, 32'h0);
	expectStore(32'h48, sext16(immV));
	runProgram();
endtask

task automatic testBranches();
	logic [15:0] immX;
	curTest = "branches";
	immX = randHalf();
	emit(encI(mipsPkg::OP_ADDI, 5'd1, 5'd0, immX));
	emit(encI(mipsPkg::OP_ADDI, 5'd2, 5'd0, immX));
	// taken and lands on the r5 write
	emit(encI(mipsPkg::OP_BEQ, 5'd2, 5'd1, 16'd2));
	emit(encI(mipsPkg::OP_ADDI, 5'd3, 5'd0, 16'd1));
	emit(encI(mipsPkg::OP_ADDI, 5'd4, 5'd0, 16'd2));
	emit(encI(mipsPkg::OP_ADDI, 5'd5, 5'd0, 16'd3));
	emit(encI(mipsPkg::OP_BNE, 5'd2, 5'd1, 16'd1));
	emit(encI(mipsPkg::OP_ADDI, 5'd6, 5'd0, 16'd4));
	emit(encI(mipsPkg::OP_ADDI, 5'd7, 5'd0, 16'd5));
	expectWb(5'd1, sext16(immX));
	expectWb(5'd2, sext16(immX));
	expectWb(5'd5, 32'd3);
	expectWb(5'd6, 32'd4);
	expectWb(5'd7, 32'd5);
	runProgram();
endtask

task automatic testRegZero();
	logic [15:0] immZ;
	logic [15:0] immW;
	curTest = "regZero";
	// nonzero so a leaked r0 write would show in r2
	immZ = randHalf() | 16'h0001;
	immW = randHalf();
	emit(encI(mipsPkg::OP_ADDI, 5'd0, 5'd0, immZ));
	emit(encI(mipsPkg::OP_ADDI, 5'd1, 5'd0, immW));
	emit(encR(mipsPkg::FN_ADD, 5'd2, 5'd0, 5'd1));
	emit(encR(mipsPkg::FN_ADD, 5'd3, 5'd0, 5'd0));
	expectWb(5'd1, sext16(immW));
	expectWb(5'd2, sext16(immW));
	expectWb(5'd3, 32'h0);
	runProgram();
endtask

task automatic testUnsupported();
	logic [15:0] immP;
	logic [15:0] immQ;
	curTest = "unsupported";
	immP = randHalf();
	immQ = randHalf();
	emit(encI(mipsPkg::OP_ADDI, 5'd1, 5'd0, immP));
	emit(encI(6'h3F, 5'd3, 5'd1, 16'h0004));
	emit(encR(6'h3F, 5'd4, 5'd1, 5'd1));
	emit(encI(mipsPkg::OP_ADDI, 5'd2, 5'd0, immQ));
	expectWb(5'd1, sext16(immP));
	expectWb(5'd2, sext16(immQ));
	runProgram();
endtask

/* test/mipsTb.sv */
// mipsTb runs directed programs on the pipelined core and checks its writebacks and stores
`timescale 1ns/10ps

module mipsTb;

	localparam int RESET_CYCLES = 16;
	localparam int PAD_WORDS = 8;
	localparam int DRAIN_CYCLES = 6;
	localparam int NUM_TESTS = 6;
	// instructions over all six directed programs
	localparam int PROG_WORDS = 35;
	localparam int CYCLE_LIMIT = (PROG_WORDS + NUM_TESTS * PAD_WORDS) * 8
		+ RESET_CYCLES * (NUM_TESTS + 1);

	logic clk;
	logic rstN;
	logic run;
	logic progWe;
	logic [7:0] progAddr;
	mipsPkg::wordT progData;
	logic wbValid;
	mipsPkg::regAddrT wbDest;
	mipsPkg::wordT wbData;
	logic memWe;
	mipsPkg::wordT memAddr;
	mipsPkg::wordT memWdata;

	logic [15:0] lfsrState = 16'd29;
	int cycles = 0;
	int valueErrs = 0;
	int eventErrs = 0;
	string curTest = "none";

	mipsPkg::wordT prog[$];
	mipsPkg::regAddrT expWbDest[$];
	mipsPkg::wordT expWbData[$];
	mipsPkg::wordT expStAddr[$];
	mipsPkg::wordT expStData[$];
	mipsPkg::regAddrT gotWbDest[$];
	mipsPkg::wordT gotWbData[$];
	mipsPkg::wordT gotStAddr[$];
	mipsPkg::wordT gotStData[$];

	mipsCore dut_i (
		.clk(clk), .rstN(rstN), .run(run), .progWe(progWe), .progAddr(progAddr),
		.progData(progData), .wbValid(wbValid), .wbDest(wbDest), .wbData(wbData),
		.memWe(memWe), .memAddr(memAddr), .memWdata(memWdata)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// taps 16 14 13 11
	function automatic logic stepLfsr();
		logic fb;
		fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
		lfsrState = {lfsrState[14:0], fb};
		return fb;
	endfunction

	function automatic logic [15:0] randHalf();
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < 16; i++) begin
			v = {v[14:0], stepLfsr()};
		end
		return v;
	endfunction

	function automatic mipsPkg::wordT sext16(logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	// differing signs decide directly and equal signs cannot overflow the difference
	function automatic mipsPkg::wordT sltValue(mipsPkg::wordT x, mipsPkg::wordT y);
		mipsPkg::wordT diff;
		diff = x - y;
		if (x[31] != y[31]) begin
			return {31'd0, x[31]};
		end
		return {31'd0, diff[31]};
	endfunction

	task automatic compareReg(string name, mipsPkg::regAddrT got, mipsPkg::regAddrT exp);
		if (got !== exp) begin
			$display("FAILED %s in %s: got 0x%h, expected 0x%h", name, curTest, got, exp);
			valueErrs++;
		end
	endtask

	task automatic compareWord(string name, mipsPkg::wordT got, mipsPkg::wordT exp);
		if (got !== exp) begin
			$display("FAILED %s in %s: got 0x%h, expected 0x%h", name, curTest, got, exp);
			valueErrs++;
		end
	endtask

	task automatic emit(mipsPkg::wordT w);
		prog.push_back(w);
	endtask

	task automatic expectWb(mipsPkg::regAddrT dest, mipsPkg::wordT data);
		expWbDest.push_back(dest);
		expWbData.push_back(data);
	endtask

	task automatic expectStore(mipsPkg::wordT addr, mipsPkg::wordT data);
		expStAddr.push_back(addr);
		expStData.push_back(data);
	endtask

	// trailing no-ops keep stale words of earlier programs out of reach
	task automatic loadProgram();
		for (int i = 0; i < prog.size() + PAD_WORDS; i++) begin
			@(posedge clk);
			progWe <= 1'b1;
			progAddr <= 8'(i);
			if (i < prog.size()) begin
				progData <= prog[i];
			end else begin
				progData <= '0;
			end
		end
		@(posedge clk);
		progWe <= 1'b0;
	endtask

	task automatic applyReset();
		@(posedge clk);
		rstN <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rstN <= 1'b1;
	endtask

	task automatic checkEvents();
		for (int i = 0; i < expWbDest.size(); i++) begin
			if (i < gotWbDest.size()) begin
				compareReg("wbDest", gotWbDest[i], expWbDest[i]);
				compareWord("wbData", gotWbData[i], expWbData[i]);
			end else begin
				$display("%s: writeback %0d to r%0d never happened", curTest, i, expWbDest[i]);
				eventErrs++;
			end
		end
		if (gotWbDest.size() > expWbDest.size()) begin
			$display("%s: %0d writebacks seen but only %0d expected", curTest,
				gotWbDest.size(), expWbDest.size());
			eventErrs++;
		end
		for (int i = 0; i < expStAddr.size(); i++) begin
			if (i < gotStAddr.size()) begin
				compareWord("memAddr", gotStAddr[i], expStAddr[i]);
				compareWord("memWdata", gotStData[i], expStData[i]);
			end else begin
				$display("%s: store %0d never reached the memory stage", curTest, i);
				eventErrs++;
			end
		end
		if (gotStAddr.size() > expStAddr.size()) begin
			$display("%s: %0d stores seen but only %0d expected", curTest,
				gotStAddr.size(), expStAddr.size());
			eventErrs++;
		end
	endtask

	task automatic runProgram();
		loadProgram();
		applyReset();
		gotWbDest.delete();
		gotWbData.delete();
		gotStAddr.delete();
		gotStData.delete();
		run <= 1'b1;
		while (gotWbDest.size() < expWbDest.size() || gotStAddr.size() < expStAddr.size()) begin
			@(posedge clk);
		end
		// halt fetch, then watch the pipeline empty for stray events
		run <= 1'b0;
		repeat (DRAIN_CYCLES) @(posedge clk);
		checkEvents();
		prog.delete();
		expWbDest.delete();
		expWbData.delete();
		expStAddr.delete();
		expStData.delete();
	endtask

	task automatic printCounts();
		$display("errors: %0d value, %0d event", valueErrs, eventErrs);
	endtask

	`include "mipsTests.svh"

	// writeback and store events in arrival order
	always @(negedge clk) begin
		if (rstN && wbValid) begin
			gotWbDest.push_back(wbDest);
			gotWbData.push_back(wbData);
		end
		if (rstN && memWe) begin
			gotStAddr.push_back(memAddr);
			gotStData.push_back(memWdata);
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout: run aborted after %0d cycles in %s", cycles, curTest);
			printCounts();
			$display("sim failed");
			$finish;
		end
	end

	initial begin
		rstN = 1'b0;
		run = 1'b0;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rstN <= 1'b1;
		testAluChain();
		testDependency();
		testStoreLoad();
		testBranches();
		testRegZero();
		testUnsupported();
		printCounts();
		if (valueErrs + eventErrs == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
